// ==== bench/clock_gen.sv ====
`timescale 1ns/10ps

module clock_gen #(
    parameter int PERIOD       = 100,
    parameter int RESET_CYCLES = 5
) (
    output logic clk,
    output logic rst
);

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    // reset released a little after the edge that ends it
    initial begin
        rst = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst = 1'b0;
    end

endmodule

// ==== bench/rename_core_tb.sv ====
`timescale 1ns/10ps

module rename_core_tb;

    import rv32i_types::*;

    localparam int ROB_IDX_WIDTH = 3;
    localparam int DEPTH         = 2 ** ROB_IDX_WIDTH;
    localparam int RESET_CYCLES  = 5;
    localparam int DRIVE_DELAY   = 10;
    localparam int N_RANDOM      = 300;
    // worst case cycles for one drain of the buffer
    localparam int DRAIN_MAX     = 4 * DEPTH;
    localparam int STIM_CYCLES   = RESET_CYCLES + 4 + N_RANDOM + 5 * DRAIN_MAX + 2 * DEPTH + 40;
    localparam int CYCLE_LIMIT   = 2 * STIM_CYCLES;

    logic              clk;
    logic              rst;
    id_dis_stage_reg_t dispatch;
    cdb_t              wb;
    logic              dispatch_ready;
    logic [ROB_IDX_WIDTH-1:0] dispatch_rob_idx;
    operand_t          rs1_op;
    operand_t          rs2_op;
    commit_t           commit;

    logic [31:0] seed;
    int          err_count;
    int          tests_passed;
    int          tests_failed;
    int          cycle_count;

    // reference model state
    logic [XLEN-1:0]          arf_m    [NUM_ARCH_REGS];
    logic                     map_pend [NUM_ARCH_REGS];
    logic [ROB_IDX_WIDTH-1:0] map_slot [NUM_ARCH_REGS];
    logic                     m_alloc  [DEPTH];
    logic                     m_done   [DEPTH];
    logic [REG_ADDR_WIDTH-1:0] m_rd    [DEPTH];
    logic [XLEN-1:0]          m_data   [DEPTH];
    logic [ROB_IDX_WIDTH-1:0] head_m;
    logic [ROB_IDX_WIDTH-1:0] tail_m;
    int                       count_m;

    // expected outputs derived from the model
    logic     exp_ready;
    logic     exp_retire;
    logic     exp_we;
    operand_t exp_op [2];

    clock_gen #(
        .PERIOD       (100),
        .RESET_CYCLES (RESET_CYCLES)
    ) clock_gen0 (
        .clk (clk),
        .rst (rst)
    );

    rename_core #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH)
    ) dut0 (
        .clk              (clk),
        .rst              (rst),
        .dispatch         (dispatch),
        .wb               (wb),
        .dispatch_ready   (dispatch_ready),
        .dispatch_rob_idx (dispatch_rob_idx),
        .rs1_op           (rs1_op),
        .rs2_op           (rs2_op),
        .commit           (commit)
    );

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic next_rand(output logic [31:0] r);
        seed = xorshift32(seed);
        r = seed;
    endtask

    task automatic report_fail(input string msg);
        $display("Fail at %0t: %s", $time, msg);
        err_count++;
    endtask

    // ready compares value, not ready compares producer slot
    function automatic bit op_matches(input operand_t got, input operand_t exp);
        if (got.ready !== exp.ready) begin
            return 1'b0;
        end
        if (exp.ready) begin
            return got.value === exp.value;
        end
        return got.rob_idx[ROB_IDX_WIDTH-1:0] === exp.rob_idx[ROB_IDX_WIDTH-1:0];
    endfunction

    assign exp_ready  = (count_m != DEPTH);
    assign exp_retire = m_alloc[head_m] && m_done[head_m];
    assign exp_we     = exp_retire && (m_rd[head_m] != '0);

    // source resolution: x0, architectural, bypass or pending
    always_comb begin
        logic [REG_ADDR_WIDTH-1:0] src;
        logic [ROB_IDX_WIDTH-1:0]  p;
        for (int k = 0; k < 2; k++) begin
            src = (k == 0) ? dispatch.rs1_addr : dispatch.rs2_addr;
            p   = map_slot[src];
            exp_op[k] = '0;
            if (src == '0) begin
                exp_op[k].ready = 1'b1;
            end else if (!map_pend[src]) begin
                exp_op[k].ready = 1'b1;
                exp_op[k].value = arf_m[src];
            end else if (m_done[p]) begin
                exp_op[k].ready = 1'b1;
                exp_op[k].value = m_data[p];
            end else begin
                exp_op[k].rob_idx = ROB_IDX_MAX_WIDTH'(p);
            end
        end
    end

    // model follows the edge, dispatch mapping wins over retire
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                arf_m[i]    <= '0;
                map_pend[i] <= 1'b0;
                map_slot[i] <= '0;
            end
            for (int i = 0; i < DEPTH; i++) begin
                m_alloc[i] <= 1'b0;
                m_done[i]  <= 1'b0;
            end
            head_m  <= '0;
            tail_m  <= '0;
            count_m <= 0;
        end else begin
            if (exp_retire) begin
                m_alloc[head_m] <= 1'b0;
                head_m <= head_m + 1'b1;
                if (m_rd[head_m] != '0) begin
                    arf_m[m_rd[head_m]] <= m_data[head_m];
                    if (map_slot[m_rd[head_m]] == head_m) begin
                        map_pend[m_rd[head_m]] <= 1'b0;
                    end
                end
            end
            if (wb.valid) begin
                m_done[wb.rob_idx[ROB_IDX_WIDTH-1:0]] <= 1'b1;
                m_data[wb.rob_idx[ROB_IDX_WIDTH-1:0]] <= wb.data;
            end
            if (dispatch.valid) begin
                m_alloc[tail_m] <= 1'b1;
                m_done[tail_m]  <= 1'b0;
                m_rd[tail_m]    <= dispatch.rd_addr;
                tail_m <= tail_m + 1'b1;
                if (dispatch.rd_addr != '0) begin
                    map_pend[dispatch.rd_addr] <= 1'b1;
                    map_slot[dispatch.rd_addr] <= tail_m;
                end
            end
            count_m <= count_m + (dispatch.valid ? 1 : 0) - (exp_retire ? 1 : 0);
        end
    end

    ready_level: assert property (
        @(posedge clk) disable iff (rst)
        dispatch_ready == exp_ready
    ) else report_fail("dispatch_ready differs from model");

    tail_slot: assert property (
        @(posedge clk) disable iff (rst)
        dispatch.valid |-> (dispatch_rob_idx == tail_m)
    ) else report_fail("dispatch_rob_idx differs from model tail");

    rs1_lookup: assert property (
        @(posedge clk) disable iff (rst)
        op_matches(rs1_op, exp_op[0])
    ) else report_fail("rs1_op differs from model");

    rs2_lookup: assert property (
        @(posedge clk) disable iff (rst)
        op_matches(rs2_op, exp_op[1])
    ) else report_fail("rs2_op differs from model");

    commit_enable: assert property (
        @(posedge clk) disable iff (rst)
        commit.regf_we == exp_we
    ) else report_fail("commit.regf_we differs from model");

    // payload only meaningful on a register write
    commit_payload: assert property (
        @(posedge clk) disable iff (rst)
        exp_we |-> (commit.rd_addr == m_rd[head_m]
                    && commit.rob_idx[ROB_IDX_WIDTH-1:0] == head_m
                    && commit.commit_data == m_data[head_m])
    ) else report_fail("commit payload differs from model");

    // inputs change only after the edge
    task automatic step();
        @(posedge clk);
        #DRIVE_DELAY;
        dispatch = '0;
        wb       = '0;
    endtask

    task automatic pick_pending(output bit found, output int slot);
        logic [31:0] r;
        int s;
        next_rand(r);
        found = 1'b0;
        slot  = 0;
        for (int i = 0; i < DEPTH; i++) begin
            s = (int'(r[7:0]) + i) % DEPTH;
            if (!found && m_alloc[s] && !m_done[s]) begin
                found = 1'b1;
                slot  = s;
            end
        end
    endtask

    task automatic drive_wb(input int slot);
        logic [31:0] r;
        next_rand(r);
        wb.valid   = 1'b1;
        wb.data    = r;
        wb.rob_idx = ROB_IDX_MAX_WIDTH'(slot);
    endtask

    task automatic drive_dispatch(input int rd, input int rs1, input int rs2);
        dispatch.valid    = 1'b1;
        dispatch.rd_addr  = REG_ADDR_WIDTH'(rd);
        dispatch.rs1_addr = REG_ADDR_WIDTH'(rs1);
        dispatch.rs2_addr = REG_ADDR_WIDTH'(rs2);
    endtask

    // finish every pending entry until the buffer is empty
    task automatic drain();
        bit found;
        int slot;
        int n;
        n = 0;
        while (count_m != 0 && n < DRAIN_MAX) begin
            step();
            pick_pending(found, slot);
            if (found) begin
                drive_wb(slot);
            end
            n++;
        end
        if (count_m != 0) begin
            $display("reorder buffer did not drain at %0t", $time);
            err_count++;
        end
        step();
    endtask

    task automatic finish_test(input string name, input int errs_before);
        if (err_count == errs_before) begin
            $display("test %s: passed", name);
            tests_passed++;
        end else begin
            $display("test %s: failed with %0d errors", name, err_count - errs_before);
            tests_failed++;
        end
    endtask

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("run timed out after %0d cycles", cycle_count);
            $display("Some tests failed");
            $finish;
        end
    end

    initial begin
        logic [31:0] r;
        bit found;
        int slot;
        int errs;
        int slot_a;
        int slot_b;
        seed         = 32'he85c_60dc;
        err_count    = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycle_count  = 0;
        dispatch     = '0;
        wb           = '0;
        wait (rst == 1'b0);

        // lookups right after reset, no dispatch
        errs = err_count;
        for (int i = 0; i < 4; i++) begin
            step();
            next_rand(r);
            dispatch.rs1_addr = r[4:0];
            dispatch.rs2_addr = r[9:5];
        end
        finish_test("reset_state", errs);

        // random dispatch and out of order writeback
        errs = err_count;
        for (int i = 0; i < N_RANDOM; i++) begin
            step();
            next_rand(r);
            if (exp_ready && r[1:0] != 2'b00) begin
                drive_dispatch(int'(r[4:2]), int'(r[7:5]), int'(r[10:8]));
            end
            pick_pending(found, slot);
            if (found && r[11]) begin
                drive_wb(slot);
            end
        end
        drain();
        finish_test("random_traffic", errs);

        // older producer retire keeps the register pending
        errs = err_count;
        step();
        slot_a = int'(tail_m);
        drive_dispatch(5, 0, 0);
        step();
        slot_b = int'(tail_m);
        drive_dispatch(5, 0, 0);
        step();
        drive_wb(slot_a);
        step();
        step();
        drive_dispatch(6, 5, 5);
        step();
        drive_wb(slot_b);
        step();
        // producer done, not yet retired
        drive_dispatch(7, 5, 6);
        drain();
        finish_test("rename_bypass", errs);

        // fill without retires, then free one slot
        errs = err_count;
        for (int i = 0; i < DEPTH; i++) begin
            step();
            drive_dispatch(i + 1, i, i + 2);
        end
        for (int i = 0; i < 3; i++) begin
            step();
        end
        drive_wb(int'(head_m));
        for (int i = 0; i < 4; i++) begin
            step();
        end
        drain();
        finish_test("full_buffer", errs);

        // x0 destinations and sources
        errs = err_count;
        for (int i = 0; i < 6; i++) begin
            step();
            next_rand(r);
            drive_dispatch(0, 0, int'(r[2:0]));
            pick_pending(found, slot);
            if (found) begin
                drive_wb(slot);
            end
        end
        drain();
        finish_test("x0_register", errs);

        step();
        step();
        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, err_count);
        if (err_count == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# build and run the rename core testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --top-module rename_core_tb \
    --Mdir obj_dir \
    -o rename_core_sim \
    -f sources.f

./obj_dir/rename_core_sim > sim.log 2>&1
cat sim.log

if grep -q "All tests passed" sim.log; then
    echo "simulation ok"
else
    echo "simulation reported errors"
    exit 1
fi

// ==== sources.f ====
src/rv32i_types.sv
src/rat_arf.sv
src/rob.sv
src/operand_fetch.sv
src/rename_core.sv
bench/clock_gen.sv
bench/rename_core_tb.sv

// ==== src/operand_fetch.sv ====
`timescale 1ns/10ps

module operand_fetch #(
    parameter int ROB_IDX_WIDTH = 3
) (
    // source register to resolve
    input  logic [rv32i_types::REG_ADDR_WIDTH-1:0] src_addr,
    // architectural state and current mapping
    input  logic [rv32i_types::XLEN-1:0]           arf_data    [rv32i_types::NUM_ARCH_REGS],
    input  logic                                   arf_ready   [rv32i_types::NUM_ARCH_REGS],
    input  logic [ROB_IDX_WIDTH-1:0]               arf_rob_idx [rv32i_types::NUM_ARCH_REGS],
    // finished but not yet retired results
    input  logic                                   entry_done  [2**ROB_IDX_WIDTH],
    input  logic [rv32i_types::XLEN-1:0]           entry_data  [2**ROB_IDX_WIDTH],
    output rv32i_types::operand_t                  op
);

    import rv32i_types::*;

    // slot that will produce this register
    logic [ROB_IDX_WIDTH-1:0] producer;

    assign producer = arf_rob_idx[src_addr];

    always_comb begin
        op.ready   = 1'b0;
        op.value   = '0;
        op.rob_idx = ROB_IDX_MAX_WIDTH'(producer);
        if (src_addr == '0) begin
            // x0 reads zero, never pending
            op.ready   = 1'b1;
            op.rob_idx = '0;
        end else if (arf_ready[src_addr]) begin
            // no producer in flight
            op.ready = 1'b1;
            op.value = arf_data[src_addr];
        end else if (entry_done[producer]) begin
            // producer finished, value still in the rob
            op.ready = 1'b1;
            op.value = entry_data[producer];
        end
        // else wait on producer, index already set
    end

endmodule

// ==== src/rat_arf.sv ====
`timescale 1ns/10ps

module rat_arf #(
    parameter int ROB_IDX_WIDTH = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    // new mapping from dispatch
    input  rv32i_types::id_dis_stage_reg_t     dispatch,
    input  logic [ROB_IDX_WIDTH-1:0]           rd_rob_idx,
    // retire from the rob head
    input  rv32i_types::commit_t               cdbus,
    // per register lookup arrays
    output logic [rv32i_types::XLEN-1:0]       data    [rv32i_types::NUM_ARCH_REGS],
    output logic                               ready   [rv32i_types::NUM_ARCH_REGS],
    output logic [ROB_IDX_WIDTH-1:0]           rob_idx [rv32i_types::NUM_ARCH_REGS]
);

    import rv32i_types::*;

    // one hot decode of the two write sources
    logic [NUM_ARCH_REGS-1:0] dispatch_hit;
    logic [NUM_ARCH_REGS-1:0] retire_hit;
    logic [ROB_IDX_WIDTH-1:0] retire_idx;

    // narrow the retiring slot to the real index width
    assign retire_idx = cdbus.rob_idx[ROB_IDX_WIDTH-1:0];

    always_comb begin
        for (int i = 0; i < NUM_ARCH_REGS; i++) begin
            // x0 is never renamed nor written
            dispatch_hit[i] = dispatch.valid && (dispatch.rd_addr == REG_ADDR_WIDTH'(i))
                              && (i != 0);
            retire_hit[i]   = cdbus.regf_we && (cdbus.rd_addr == REG_ADDR_WIDTH'(i))
                              && (i != 0);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            // everything starts architectural, zero and ready
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                data[i]    <= '0;
                ready[i]   <= 1'b1;
                rob_idx[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_ARCH_REGS; i++) begin
                // architectural value always takes the retiring result
                if (retire_hit[i]) begin
                    data[i] <= cdbus.commit_data;
                end
                // a fresh mapping wins over a retire in the same cycle
                if (dispatch_hit[i]) begin
                    rob_idx[i] <= rd_rob_idx;
                    ready[i]   <= 1'b0;
                end else if (retire_hit[i] && (rob_idx[i] == retire_idx)) begin
                    // only the latest producer releases the register
                    ready[i] <= 1'b1;
                end
            end
        end
    end

    // x0 stays hardwired through any dispatch and retire traffic
    x0_always_zero: assert property (
        @(posedge clk) disable iff (rst)
        ready[0] && (data[0] == '0)
    ) else $error("rat_arf: x0 lost its ready zero state");

endmodule

// ==== src/rename_core.sv ====
`timescale 1ns/10ps

module rename_core #(
    parameter int ROB_IDX_WIDTH = 3
) (
    input  logic                           clk,
    input  logic                           rst,
    input  rv32i_types::id_dis_stage_reg_t dispatch,
    input  rv32i_types::cdb_t              wb,
    output logic                           dispatch_ready,
    // slot given to the instruction on dispatch
    output logic [ROB_IDX_WIDTH-1:0]       dispatch_rob_idx,
    output rv32i_types::operand_t          rs1_op,
    output rv32i_types::operand_t          rs2_op,
    output rv32i_types::commit_t           commit
);

    import rv32i_types::*;

    localparam int DEPTH = 2 ** ROB_IDX_WIDTH;

    // rob slot status toward the bypass paths
    logic                     entry_done  [DEPTH];
    logic [XLEN-1:0]          entry_data  [DEPTH];

    // alias table and architectural values
    logic [XLEN-1:0]          arf_data    [NUM_ARCH_REGS];
    logic                     arf_ready   [NUM_ARCH_REGS];
    logic [ROB_IDX_WIDTH-1:0] arf_rob_idx [NUM_ARCH_REGS];

    rob #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH)
    ) rob0 (
        .clk            (clk),
        .rst            (rst),
        .dispatch       (dispatch),
        .wb             (wb),
        .dispatch_ready (dispatch_ready),
        .tail_idx       (dispatch_rob_idx),
        .entry_done     (entry_done),
        .entry_data     (entry_data),
        .commit         (commit)
    );

    // rename rd to the tail slot, retire from the head
    rat_arf #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH)
    ) rat_arf0 (
        .clk        (clk),
        .rst        (rst),
        .dispatch   (dispatch),
        .rd_rob_idx (dispatch_rob_idx),
        .cdbus      (commit),
        .data       (arf_data),
        .ready      (arf_ready),
        .rob_idx    (arf_rob_idx)
    );

    // both sources see state from before this edge
    operand_fetch #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH)
    ) rs1_fetch (
        .src_addr    (dispatch.rs1_addr),
        .arf_data    (arf_data),
        .arf_ready   (arf_ready),
        .arf_rob_idx (arf_rob_idx),
        .entry_done  (entry_done),
        .entry_data  (entry_data),
        .op          (rs1_op)
    );

    operand_fetch #(
        .ROB_IDX_WIDTH (ROB_IDX_WIDTH)
    ) rs2_fetch (
        .src_addr    (dispatch.rs2_addr),
        .arf_data    (arf_data),
        .arf_ready   (arf_ready),
        .arf_rob_idx (arf_rob_idx),
        .entry_done  (entry_done),
        .entry_data  (entry_data),
        .op          (rs2_op)
    );

endmodule

// ==== src/rob.sv ====
`timescale 1ns/10ps

module rob #(
    parameter int ROB_IDX_WIDTH = 3
) (
    input  logic                               clk,
    input  logic                               rst,
    input  rv32i_types::id_dis_stage_reg_t     dispatch,
    input  rv32i_types::cdb_t                  wb,
    // low only while every slot is allocated
    output logic                               dispatch_ready,
    output logic [ROB_IDX_WIDTH-1:0]           tail_idx,
    // per slot status for operand bypass
    output logic                               entry_done [2**ROB_IDX_WIDTH],
    output logic [rv32i_types::XLEN-1:0]       entry_data [2**ROB_IDX_WIDTH],
    output rv32i_types::commit_t               commit
);

    import rv32i_types::*;

    localparam int DEPTH = 2 ** ROB_IDX_WIDTH;

    // per slot control state and pointers
    logic                       valid [DEPTH];
    logic                       done  [DEPTH];
    logic [ROB_IDX_WIDTH-1:0]   head;
    logic [ROB_IDX_WIDTH-1:0]   tail;
    // one extra bit so full and empty differ
    logic [ROB_IDX_WIDTH:0]     count;

    // per slot payload
    logic [REG_ADDR_WIDTH-1:0]  rd_addr [DEPTH];
    logic [XLEN-1:0]            data    [DEPTH];

    logic                       retire;
    logic [ROB_IDX_WIDTH-1:0]   wb_idx;

    assign wb_idx = wb.rob_idx[ROB_IDX_WIDTH-1:0];

    // head leaves once its result is in
    assign retire = valid[head] && done[head];

    // count is registered so a retire frees space one cycle later
    assign dispatch_ready = (count != (ROB_IDX_WIDTH + 1)'(DEPTH));
    assign tail_idx       = tail;

    assign entry_done = done;
    assign entry_data = data;

    always_comb begin
        // x0 destinations still retire without a register write
        commit.regf_we     = retire && (rd_addr[head] != '0);
        commit.rd_addr     = rd_addr[head];
        commit.rob_idx     = ROB_IDX_MAX_WIDTH'(head);
        commit.commit_data = data[head];
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < DEPTH; i++) begin
                valid[i] <= 1'b0;
                done[i]  <= 1'b0;
            end
        end else begin
            // allocate at the tail
            if (dispatch.valid) begin
                valid[tail] <= 1'b1;
                done[tail]  <= 1'b0;
                tail        <= tail + 1'b1;
            end
            // result bus marks its slot finished
            if (wb.valid) begin
                done[wb_idx] <= 1'b1;
            end
            // in order release at the head
            if (retire) begin
                valid[head] <= 1'b0;
                head        <= head + 1'b1;
            end
            unique case ({dispatch.valid, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // destination register and result payload
    always_ff @(posedge clk) begin
        if (dispatch.valid) begin
            rd_addr[tail] <= dispatch.rd_addr;
        end
        if (wb.valid) begin
            data[wb_idx] <= wb.data;
        end
    end

    // producer must honour the ready level
    no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (rst)
        dispatch.valid |-> dispatch_ready
    ) else $error("rob: dispatch while full");

    // execution side may only finish live, unfinished slots
    wb_to_live_entry: assert property (
        @(posedge clk) disable iff (rst)
        wb.valid |-> (valid[wb_idx] && !done[wb_idx])
    ) else $error("rob: writeback to free or finished slot %0d", wb_idx);

endmodule

// ==== src/rv32i_types.sv ====
package rv32i_types;

    // machine word and register file geometry
    localparam int XLEN           = 32;
    localparam int NUM_ARCH_REGS  = 32;
    localparam int REG_ADDR_WIDTH = 5;

    // rob index fields are carried at full width
    // only the low ROB_IDX_WIDTH bits are meaningful
    localparam int ROB_IDX_MAX_WIDTH = 8;

    // decoded instruction handed to dispatch, 16 bits
    typedef struct packed {
        logic                      valid;
        logic [REG_ADDR_WIDTH-1:0] rs1_addr;
        logic [REG_ADDR_WIDTH-1:0] rs2_addr;
        logic [REG_ADDR_WIDTH-1:0] rd_addr;
    } id_dis_stage_reg_t;

    // result bus transfer from an execution unit, 41 bits
    typedef struct packed {
        logic                         valid;
        logic [XLEN-1:0]              data;
        // producing rob slot
        logic [ROB_IDX_MAX_WIDTH-1:0] rob_idx;
    } cdb_t;

    // retire transfer from the rob head, 46 bits
    typedef struct packed {
        // low when the head writes x0 or nothing retires
        logic                         regf_we;
        logic [REG_ADDR_WIDTH-1:0]    rd_addr;
        logic [ROB_IDX_MAX_WIDTH-1:0] rob_idx;
        logic [XLEN-1:0]              commit_data;
    } commit_t;

    // one resolved source operand, 41 bits
    typedef struct packed {
        logic                         ready;
        // valid only while ready is high
        logic [XLEN-1:0]              value;
        // producer slot, meaningful only while ready is low
        logic [ROB_IDX_MAX_WIDTH-1:0] rob_idx;
    } operand_t;

endpackage
